// ==== xfer_mem_top.f ====
rtl/wb_bus_pkg.sv
rtl/xfer_pkg.sv
rtl/wb_mem.sv
rtl/xfer_word_counter.sv
rtl/xfer_datapath.sv
rtl/xfer_ctrl_fsm.sv
rtl/xfer_mem_top.sv
testbench/tb_xfer_mem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_xfer_mem_top \
    -f xfer_mem_top.f -o sim_xfer_mem \
    && ./obj_dir/sim_xfer_mem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// ==== testbench/tb_xfer_mem_top.sv ====
`default_nettype none

module tb_xfer_mem_top;
    import wb_bus_pkg::*;
    import xfer_pkg::*;

    localparam int DATA_WIDTH  = DEFAULT_DATA_WIDTH;
    localparam int MEM_SIZE_KB = DEFAULT_MEM_SIZE_KB;
    localparam int MEM_DEPTH   = (MEM_SIZE_KB * 8192) / DATA_WIDTH;
    localparam int ADDR_WIDTH  = $clog2(MEM_DEPTH);
    localparam logic [31:0] POKE_WORD = 32'hBAD0_BAD0;  // Never expected in memory

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    xfer_op_t              cmd_op;
    logic [ADDR_WIDTH-1:0] src_addr;
    logic [ADDR_WIDTH-1:0] dst_addr;
    logic [ADDR_WIDTH:0]   len;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  busy_o;
    logic                  done_o;
    logic [DATA_WIDTH-1:0] rdata_o;

    // Stimulus table, one entry per command
    string       t_name [$];
    xfer_op_t    t_op   [$];
    int          t_src  [$];
    int          t_dst  [$];
    int          t_len  [$];
    logic [31:0] t_word [$];
    bit          t_rnd  [$];  // Word drawn from $random
    int          t_poke [$];  // Host write strobed while busy, -1 for none
    bit          t_fixed[$];  // Read result checked against t_exp
    logic [31:0] t_exp  [$];

    logic [DATA_WIDTH-1:0] model [];  // Reference memory
    integer seed;
    int     errors;
    int     failed_tests;
    bit     table_ready;
    longint wd_time;

    xfer_mem_top #(.DATA_WIDTH(DATA_WIDTH), .MEM_SIZE_KB(MEM_SIZE_KB)) i_xfer_mem_top (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid_i(cmd_valid),
        .cmd_op_i   (cmd_op),
        .src_addr_i (src_addr),
        .dst_addr_i (dst_addr),
        .len_i      (len),
        .wdata_i    (wdata),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .rdata_o    (rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // Period 40
    end

    task automatic add_cmd(input string name, input xfer_op_t op, input int src, input int dst,
                           input int len_w, input logic [31:0] word, input bit rnd,
                           input int poke);
        t_name.push_back(name);
        t_op.push_back(op);
        t_src.push_back(src);
        t_dst.push_back(dst);
        t_len.push_back(len_w);
        t_word.push_back(word);
        t_rnd.push_back(rnd);
        t_poke.push_back(poke);
        t_fixed.push_back(1'b0);
        t_exp.push_back('0);
    endtask

    // Host read of one word, result from the table or the model
    task automatic add_read(input string name, input int adr, input bit fixed,
                            input logic [31:0] exp);
        add_cmd(name, OP_HOST_READ, adr, 0, 1, '0, 1'b0, -1);
        t_fixed[t_fixed.size()-1] = fixed;
        t_exp[t_exp.size()-1]     = exp;
    endtask

    task automatic build_table();
        add_read("rst_rd_0", 0, 1'b1, MEM_RESET_WORD);
        add_read("rst_rd_17", 17, 1'b1, MEM_RESET_WORD);
        add_read("rst_rd_255", 255, 1'b1, MEM_RESET_WORD);
        add_cmd("wr_20", OP_HOST_WRITE, 0, 20, 1, 32'hA5A5_0014, 1'b0, -1);
        add_read("rd_20", 20, 1'b1, 32'hA5A5_0014);
        add_read("rd_21", 21, 1'b1, MEM_RESET_WORD);  // Neighbour untouched
        add_cmd("fill_40_x12", OP_FILL, 0, 40, 12, '0, 1'b1, -1);
        add_read("rd_51", 51, 1'b0, '0);
        add_read("rd_39", 39, 1'b1, MEM_RESET_WORD);
        add_read("rd_52", 52, 1'b1, MEM_RESET_WORD);
        add_cmd("copy_40_100", OP_COPY, 40, 100, 12, '0, 1'b0, -1);
        add_read("rd_111", 111, 1'b0, '0);
        add_read("rd_src_40", 40, 1'b0, '0);  // Source intact
        add_cmd("copy_ovl_98_101", OP_COPY, 98, 101, 8, '0, 1'b0, -1);  // Mixed data overlap
        add_read("rd_104", 104, 1'b0, '0);
        add_read("rd_106", 106, 1'b0, '0);
        add_cmd("copy_wrap_36_250", OP_COPY, 36, 250, 10, '0, 1'b0, -1);  // Dest wraps to 3
        add_read("rd_254", 254, 1'b0, '0);
        add_read("rd_3", 3, 1'b0, '0);
        add_cmd("fill_busy_drop", OP_FILL, 0, 150, 6, '0, 1'b1, 200);
        add_read("rd_200", 200, 1'b1, MEM_RESET_WORD);
        add_cmd("fill_len0", OP_FILL, 0, 60, 0, '0, 1'b1, -1);
        add_read("rd_60", 60, 1'b1, MEM_RESET_WORD);
    endtask

    // Forward, word by word, wrapping at the depth
    task automatic apply_model(input int idx, input logic [31:0] word);
        for (int k = 0; k < t_len[idx]; k++) begin
            if (t_op[idx] == OP_FILL)
                model[(t_dst[idx] + k) % MEM_DEPTH] = word;
            else if (t_op[idx] == OP_COPY)
                model[(t_dst[idx] + k) % MEM_DEPTH] = model[(t_src[idx] + k) % MEM_DEPTH];
        end
        if (t_op[idx] == OP_HOST_WRITE)
            model[t_dst[idx] % MEM_DEPTH] = word;
    endtask

    task automatic run_test(input int idx);
        logic [31:0] word;
        logic [31:0] exp_val;
        int          cycles;
        int          limit;
        bit          seen;
        int          errs_at_start;
        errs_at_start = errors;
        word   = t_rnd[idx] ? $random(seed) : t_word[idx];
        limit  = 4 * t_len[idx] + 8;
        cycles = 0;
        seen   = 1'b0;
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = t_op[idx];
        src_addr  = ADDR_WIDTH'(t_src[idx]);
        dst_addr  = ADDR_WIDTH'(t_dst[idx]);
        len       = (ADDR_WIDTH+1)'(t_len[idx]);
        wdata     = word;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            cmd_valid = 1'b0;
            if (cycles == 1 && t_poke[idx] >= 0) begin
                assert (busy_o) else begin
                    $display("%s: engine idle when the extra command was strobed", t_name[idx]);
                    errors++;
                end
                cmd_valid = 1'b1;  // Should be dropped
                cmd_op    = OP_HOST_WRITE;
                dst_addr  = ADDR_WIDTH'(t_poke[idx]);
                wdata     = POKE_WORD;
            end
            seen = done_o;
        end
        cmd_valid = 1'b0;
        if (!seen) begin
            $display("%s: done_o did not arrive within %0d cycles", t_name[idx], limit);
            errors++;
        end else if (t_op[idx] == OP_HOST_READ) begin
            exp_val = t_fixed[idx] ? t_exp[idx] : model[t_src[idx] % MEM_DEPTH];
            assert (rdata_o === exp_val) else begin
                $display("CHECK FAILED %s: expected %h, actual %h", t_name[idx], exp_val, rdata_o);
                errors++;
            end
        end
        apply_model(idx, word);
        repeat (2) begin  // Single done pulse, then idle
            @(negedge clk);
            assert (!done_o && !busy_o) else begin
                $display("%s: done_o or busy_o high after the command ended", t_name[idx]);
                errors++;
            end
        end
        if (errors != errs_at_start)
            failed_tests++;
        $display("test %0d %s: %s", idx, t_name[idx], (errors == errs_at_start) ? "pass" : "fail");
    endtask

    initial begin : watchdog
        wait (table_ready);
        #(wd_time);
        $display("Watchdog expired at time %0t, the tests did not finish", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h23b7d94a;
        errors       = 0;
        failed_tests = 0;
        table_ready  = 1'b0;
        wd_time      = 0;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = OP_HOST_READ;
        src_addr     = '0;
        dst_addr     = '0;
        len          = '0;
        wdata        = '0;
        model = new[MEM_DEPTH];
        for (int a = 0; a < MEM_DEPTH; a++)
            model[a] = MEM_RESET_WORD;
        build_table();
        for (int i = 0; i < t_name.size(); i++)
            wd_time += 4 * t_len[i] + 16;  // Busy time, done, issue and idle checks
        wd_time     = (wd_time + 20) * 40 + 2000;
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < t_name.size(); i++)
            run_test(i);
        $display("tests %0d, failed tests %0d, errors %0d", t_name.size(), failed_tests, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/xfer_mem_top.sv ====
`default_nettype none

module xfer_mem_top #(
    parameter int DATA_WIDTH  = wb_bus_pkg::DEFAULT_DATA_WIDTH,
    parameter int MEM_SIZE_KB = wb_bus_pkg::DEFAULT_MEM_SIZE_KB,
    localparam int MEM_DEPTH  = (MEM_SIZE_KB * 8192) / DATA_WIDTH,
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cmd_valid_i,  // Ignored while busy
    input  wire xfer_pkg::xfer_op_t cmd_op_i,
    input  wire [ADDR_WIDTH-1:0] src_addr_i,
    input  wire [ADDR_WIDTH-1:0] dst_addr_i,
    input  wire [ADDR_WIDTH:0]   len_i,
    input  wire [DATA_WIDTH-1:0] wdata_i,
    output logic                 busy_o,
    output logic                 done_o,       // One pulse per command
    output logic [DATA_WIDTH-1:0] rdata_o
);

    // Internal bus
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic                  wb_ack;
    logic [ADDR_WIDTH-1:0] wb_adr;
    logic [DATA_WIDTH-1:0] wb_wdat;
    logic [DATA_WIDTH-1:0] wb_rdat;

    // Controller strobes
    logic cnt_load, cnt_dec, src_step, dst_step, cnt_zero;
    logic pat_load, rd_capture, adr_sel_dst, wdat_sel_rd;

    // Running addresses
    logic [ADDR_WIDTH-1:0] src_addr;
    logic [ADDR_WIDTH-1:0] dst_addr;

    xfer_ctrl_fsm i_xfer_ctrl_fsm (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cnt_zero_i   (cnt_zero),
        .wb_ack_i     (wb_ack),
        .wb_cyc_o     (wb_cyc),
        .wb_stb_o     (wb_stb),
        .wb_we_o      (wb_we),
        .cnt_load_o   (cnt_load),
        .cnt_dec_o    (cnt_dec),
        .src_step_o   (src_step),
        .dst_step_o   (dst_step),
        .pat_load_o   (pat_load),
        .rd_capture_o (rd_capture),
        .adr_sel_dst_o(adr_sel_dst),
        .wdat_sel_rd_o(wdat_sel_rd),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    xfer_word_counter #(.DATA_WIDTH(DATA_WIDTH), .MEM_SIZE_KB(MEM_SIZE_KB)) i_xfer_word_counter (
        .clk       (clk),
        .rst       (rst),
        .cnt_load_i(cnt_load),
        .cnt_dec_i (cnt_dec),
        .src_step_i(src_step),
        .dst_step_i(dst_step),
        .len_i     (len_i),
        .src_addr_i(src_addr_i),
        .dst_addr_i(dst_addr_i),
        .src_addr_o(src_addr),
        .dst_addr_o(dst_addr),
        .cnt_zero_o(cnt_zero)
    );

    xfer_datapath #(.DATA_WIDTH(DATA_WIDTH), .MEM_SIZE_KB(MEM_SIZE_KB)) i_xfer_datapath (
        .clk          (clk),
        .rst          (rst),
        .pat_load_i   (pat_load),
        .wdata_i      (wdata_i),
        .rd_capture_i (rd_capture),
        .wb_rdat_i    (wb_rdat),
        .adr_sel_dst_i(adr_sel_dst),
        .wdat_sel_rd_i(wdat_sel_rd),
        .src_addr_i   (src_addr),
        .dst_addr_i   (dst_addr),
        .wb_adr_o     (wb_adr),
        .wb_wdat_o    (wb_wdat),
        .rdata_o      (rdata_o)
    );

    wb_mem #(.DATA_WIDTH(DATA_WIDTH), .MEM_SIZE_KB(MEM_SIZE_KB)) i_wb_mem (
        .clk     (clk),
        .rst     (rst),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_wdat),
        .wb_we_i (wb_we),
        .wb_stb_i(wb_stb),
        .wb_cyc_i(wb_cyc),
        .wb_dat_o(wb_rdat),
        .wb_ack_o(wb_ack)
    );

endmodule

`default_nettype wire

// ==== rtl/xfer_ctrl_fsm.sv ====
`default_nettype none

module xfer_ctrl_fsm (
    input  wire               clk,
    input  wire               rst,
    input  wire               cmd_valid_i,  // Single-cycle command strobe
    input  wire xfer_pkg::xfer_op_t cmd_op_i,
    input  wire               cnt_zero_i,
    input  wire               wb_ack_i,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic              cnt_load_o,
    output logic              cnt_dec_o,
    output logic              src_step_o,
    output logic              dst_step_o,
    output logic              pat_load_o,
    output logic              rd_capture_o,
    output logic              adr_sel_dst_o,
    output logic              wdat_sel_rd_o,
    output logic              busy_o,
    output logic              done_o
);
    import xfer_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        is_copy_q;  // Current command is a copy
    logic        accept;

    // Dropped while busy and taken again from ST_DONE
    assign accept = cmd_valid_i && (state_q == ST_IDLE || state_q == ST_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            is_copy_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept)
                is_copy_q <= (cmd_op_i == OP_COPY);
        end
    end

    always_comb begin
        state_d       = state_q;
        wb_stb_o      = 1'b0;
        wb_we_o       = 1'b0;
        cnt_load_o    = 1'b0;
        cnt_dec_o     = 1'b0;
        src_step_o    = 1'b0;
        dst_step_o    = 1'b0;
        pat_load_o    = 1'b0;
        rd_capture_o  = 1'b0;
        adr_sel_dst_o = 1'b0;
        wdat_sel_rd_o = 1'b0;

        case (state_q)
            ST_IDLE, ST_DONE: begin
                state_d = ST_IDLE;
                if (accept) begin
                    cnt_load_o = 1'b1;  // Length and both addresses
                    pat_load_o = 1'b1;  // Host word or pattern
                    case (cmd_op_i)
                        OP_HOST_WRITE: state_d = ST_HOST_WR;
                        OP_HOST_READ:  state_d = ST_HOST_RD;
                        OP_FILL:       state_d = ST_WRITE;
                        default:       state_d = ST_READ;
                    endcase
                end
            end

            ST_READ: begin
                wdat_sel_rd_o = 1'b1;  // Marks a copy read for the datapath
                if (cnt_zero_i) begin
                    state_d = ST_DONE;  // Zero-length copy
                end else begin
                    wb_stb_o = 1'b1;
                    if (wb_ack_i) begin
                        rd_capture_o = 1'b1;
                        src_step_o   = 1'b1;
                        state_d      = ST_WRITE;
                    end
                end
            end

            ST_WRITE: begin
                wb_we_o       = 1'b1;
                adr_sel_dst_o = 1'b1;
                wdat_sel_rd_o = is_copy_q;
                if (!wb_ack_i && cnt_zero_i) begin
                    state_d = ST_DONE;  // Only reached with zero length
                end else begin
                    wb_stb_o  = 1'b1;
                    cnt_dec_o = !wb_ack_i;  // Count drops in the first cycle
                    if (wb_ack_i) begin
                        dst_step_o = 1'b1;
                        // Count already shows the words left after this one
                        if (cnt_zero_i)
                            state_d = ST_DONE;
                        else if (is_copy_q)
                            state_d = ST_READ;
                        else
                            state_d = ST_WRITE;
                    end
                end
            end

            ST_HOST_RD: begin
                wb_stb_o = 1'b1;  // Source address selected
                if (wb_ack_i) begin
                    rd_capture_o = 1'b1;
                    state_d      = ST_DONE;
                end
            end

            ST_HOST_WR: begin
                wb_stb_o      = 1'b1;
                wb_we_o       = 1'b1;
                adr_sel_dst_o = 1'b1;
                if (wb_ack_i)
                    state_d = ST_DONE;
            end

            default: state_d = ST_IDLE;
        endcase
    end

    assign wb_cyc_o = wb_stb_o;  // Cycle follows strobe with one master
    assign done_o   = (state_q == ST_DONE);
    assign busy_o   = !(state_q == ST_IDLE || state_q == ST_DONE);

    // Memory never acks while the engine is idle or finishing
    a_no_ack_idle : assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_IDLE || state_q == ST_DONE) |-> !wb_ack_i);

endmodule

`default_nettype wire

// ==== rtl/xfer_datapath.sv ====
`default_nettype none

module xfer_datapath #(
    parameter int DATA_WIDTH  = 32,
    parameter int MEM_SIZE_KB = 1,
    localparam int MEM_DEPTH  = (MEM_SIZE_KB * 8192) / DATA_WIDTH,
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  pat_load_i,     // Command accept
    input  wire [DATA_WIDTH-1:0] wdata_i,        // Host word or fill pattern
    input  wire                  rd_capture_i,   // Read ack cycle
    input  wire [DATA_WIDTH-1:0] wb_rdat_i,
    input  wire                  adr_sel_dst_i,  // 1 = destination address
    input  wire                  wdat_sel_rd_i,  // 1 = copied read word
    input  wire [ADDR_WIDTH-1:0] src_addr_i,
    input  wire [ADDR_WIDTH-1:0] dst_addr_i,
    output logic [ADDR_WIDTH-1:0] wb_adr_o,
    output logic [DATA_WIDTH-1:0] wb_wdat_o,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    logic [DATA_WIDTH-1:0] pat_q;   // Pattern or host write word
    logic [DATA_WIDTH-1:0] rd_q;    // Word in flight during a copy
    logic [DATA_WIDTH-1:0] host_q;  // Last host read result
    logic                  host_rd; // Read capture outside a copy

    // Copy reads come with the read-word select set
    assign host_rd = rd_capture_i && !wdat_sel_rd_i;

    always_ff @(posedge clk) begin
        if (pat_load_i)
            pat_q <= wdata_i;
        if (rd_capture_i)
            rd_q <= wb_rdat_i;  // Sampled in the ack cycle
    end

    // Host result holds until the next host read completes
    always_ff @(posedge clk) begin
        if (rst)
            host_q <= '0;
        else if (host_rd)
            host_q <= wb_rdat_i;
    end

    // Bus address and write data
    always_comb begin
        if (adr_sel_dst_i)
            wb_adr_o = dst_addr_i;
        else
            wb_adr_o = src_addr_i;

        if (wdat_sel_rd_i)
            wb_wdat_o = rd_q;   // Copy
        else
            wb_wdat_o = pat_q;  // Fill or host write
    end

    assign rdata_o = host_q;

endmodule

`default_nettype wire

// ==== rtl/xfer_word_counter.sv ====
`default_nettype none

module xfer_word_counter #(
    parameter int DATA_WIDTH  = 32,
    parameter int MEM_SIZE_KB = 1,
    localparam int MEM_DEPTH  = (MEM_SIZE_KB * 8192) / DATA_WIDTH,
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cnt_load_i,  // Take length and both start addresses
    input  wire                  cnt_dec_i,   // One word done
    input  wire                  src_step_i,
    input  wire                  dst_step_i,
    input  wire [ADDR_WIDTH:0]   len_i,       // One extra bit for a full-memory length
    input  wire [ADDR_WIDTH-1:0] src_addr_i,
    input  wire [ADDR_WIDTH-1:0] dst_addr_i,
    output logic [ADDR_WIDTH-1:0] src_addr_o,
    output logic [ADDR_WIDTH-1:0] dst_addr_o,
    output logic                 cnt_zero_o
);

    logic [ADDR_WIDTH:0]   cnt_q;  // Words still to move
    logic [ADDR_WIDTH-1:0] src_q;
    logic [ADDR_WIDTH-1:0] dst_q;

    // Remaining count is control state
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (cnt_load_i) begin
            cnt_q <= len_i;
        end else if (cnt_dec_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Address counters wrap at the memory depth
    always_ff @(posedge clk) begin
        if (cnt_load_i) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
        end else begin
            if (src_step_i)
                src_q <= src_q + 1'b1;  // Natural wrap
            if (dst_step_i)
                dst_q <= dst_q + 1'b1;
        end
    end

    assign src_addr_o = src_q;
    assign dst_addr_o = dst_q;
    assign cnt_zero_o = (cnt_q == '0);  // From the registered count

    // Controller must stop before the count runs out
    a_no_dec_at_zero : assert property (@(posedge clk) disable iff (rst)
        cnt_dec_i |-> !cnt_zero_o);

endmodule

`default_nettype wire

// ==== rtl/wb_mem.sv ====
`default_nettype none

module wb_mem #(
    parameter int DATA_WIDTH  = 32,
    parameter int MEM_SIZE_KB = 1,
    localparam int MEM_DEPTH  = (MEM_SIZE_KB * 8192) / DATA_WIDTH,
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH)
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [ADDR_WIDTH-1:0] wb_adr_i,  // Word address
    input  wire [DATA_WIDTH-1:0] wb_dat_i,  // Write data
    input  wire                  wb_we_i,   // 1 = write
    input  wire                  wb_stb_i,
    input  wire                  wb_cyc_i,
    output logic [DATA_WIDTH-1:0] wb_dat_o, // Read data, combinational
    output logic                 wb_ack_o   // Registered acknowledge
);
    import wb_bus_pkg::*;

    logic [DATA_WIDTH-1:0] mem [0:MEM_DEPTH-1];
    logic                  req;  // Strobe qualified by cycle

    assign req = wb_cyc_i && wb_stb_i;

    // Ack suppressed right after it was high so each access takes two cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= DATA_WIDTH'(MEM_RESET_WORD);  // Known fill pattern
            end
        end else begin
            wb_ack_o <= req && !wb_ack_o;
            if (req && !wb_ack_o && wb_we_i) begin
                mem[wb_adr_i] <= wb_dat_i;  // Write at the edge raising ack
            end
        end
    end

    // Read data only while a read is strobed
    always_comb begin
        if (req && !wb_we_i)
            wb_dat_o = mem[wb_adr_i];
        else
            wb_dat_o = '0;
    end

    // Master keeps the request, address and direction until ack
    a_req_held : assert property (@(posedge clk) disable iff (rst)
        req && !wb_ack_o |=> req && $stable(wb_adr_i) && $stable(wb_we_i));

    // Strobe still held in the ack cycle
    a_ack_with_stb : assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |-> req);

endmodule

`default_nettype wire

// ==== rtl/xfer_pkg.sv ====
`default_nettype none

package xfer_pkg;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_HOST_WRITE = 2'd0,  // One word from wdata to dst
        OP_HOST_READ  = 2'd1,  // One word from src to rdata
        OP_FILL       = 2'd2,  // Pattern word over len words from dst
        OP_COPY       = 2'd3   // Forward copy src -> dst, len words
    } xfer_op_t;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,  // Waiting for a command
        ST_READ    = 3'd1,  // Copy read from source
        ST_WRITE   = 3'd2,  // Fill or copy write to destination
        ST_HOST_RD = 3'd3,  // Single host read
        ST_HOST_WR = 3'd4,  // Single host write
        ST_DONE    = 3'd5   // One-cycle completion pulse
    } ctrl_state_t;

    // A command is taken in ST_IDLE or ST_DONE, both with busy low

endpackage

`default_nettype wire

// ==== rtl/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

    // Every memory word takes this value at reset
    localparam logic [31:0] MEM_RESET_WORD = 32'h00000033;

    // Top-level defaults, passed down to every block
    localparam int DEFAULT_DATA_WIDTH  = 32;  // Bits per word
    localparam int DEFAULT_MEM_SIZE_KB = 1;   // 1 KB gives 256 words of 32 bits

    // Depth and address width are derived per module:
    //   MEM_DEPTH  = MEM_SIZE_KB * 8192 / DATA_WIDTH
    //   ADDR_WIDTH = $clog2(MEM_DEPTH)
    // Addresses wrap at ADDR_WIDTH bits, so depth is expected to be a power of two

endpackage

`default_nettype wire
